//--- flist.f
hw/cpu_pkg.sv
hw/alu_pkg.sv
hw/alu.sv
hw/decimal_adjust.sv
hw/arch_regs.sv
hw/alu_sequencer.sv
hw/alu_datapath.sv
test/alu_datapath_props.sv
test/tb_alu_datapath.sv

//--- test/tb_alu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_datapath
	import cpu_pkg::*, alu_pkg::*;
();

	// About 300 commands of 4 cycles, doubled for stalls and margin
	localparam int MAX_CYCLES = 300 * 4 * 2 + 600;

	logic        clk;
	logic        rst;
	logic        rdy;
	logic        cmd_valid;
	insn_class_t cmd_class;
	byte_t       cmd_operand;
	byte_t       acc;
	status_t     status;
	logic        busy;
	logic        done;

	byte_t   m_acc;           // Reference A
	status_t m_st;            // Reference flags
	integer  seed = 63;
	int      errors = 0;
	int      tests_run = 0;
	int      tests_bad = 0;
	int      cycles = 0;
	int      prop_fails;
	int      err_mark;

	alu_datapath DUT (.clk(clk), .rst(rst), .rdy(rdy), .cmd_valid(cmd_valid),
		.cmd_class(cmd_class), .cmd_operand(cmd_operand), .acc(acc), .status(status),
		.busy(busy), .done(done));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a command never finished", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		errors++;
		$display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
	endtask

	task automatic note_error(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	function automatic int from_bcd(input byte_t v);
		return v[7:4] * 10 + v[3:0];
	endfunction

	function automatic byte_t to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	task automatic set_nz(input byte_t r);
		m_st[FLAG_N] = r[7];
		m_st[FLAG_Z] = (r == 8'h00);
	endtask

	// Architectural effect of one command
	task automatic model_step(input insn_class_t cls, input byte_t opnd);
		logic       c;
		byte_t      b;
		logic [8:0] sum;
		int         sa;
		int         sb;
		int         sv;
		c = m_st[FLAG_C];
		b = (cls == CLS_ADC) ? opnd : ~opnd;  // Subtract adds the complement
		case (cls)
			CLS_ADC, CLS_SBC: begin
				if (m_st[FLAG_D]) begin
					sv = from_bcd(m_acc) + c;
					if (cls == CLS_ADC) begin
						sv = sv + from_bcd(opnd);
						m_st[FLAG_C] = (sv > 99);
					end else begin
						sv = sv - from_bcd(opnd) - 1;
						m_st[FLAG_C] = (sv >= 0);  // Clear on borrow
					end
					m_acc = to_bcd((sv + 100) % 100);
				end else begin
					sa = $signed(m_acc);
					sb = $signed(b);
					sv = sa + sb + c;
					sum = {1'b0, m_acc} + {1'b0, b} + c;
					m_acc = sum[7:0];
					m_st[FLAG_C] = sum[8];
					m_st[FLAG_V] = (sv > 127) || (sv < -128);
				end
			end
			CLS_CMP: begin
				sum = {1'b0, m_acc} + {1'b0, b} + 9'd1;
				m_st[FLAG_C] = sum[8];
				set_nz(sum[7:0]);  // A untouched
			end
			CLS_AND: m_acc = m_acc & opnd;
			CLS_ORA: m_acc = m_acc | opnd;
			CLS_EOR: m_acc = m_acc ^ opnd;
			CLS_LDA: m_acc = opnd;
			CLS_ASL: {m_st[FLAG_C], m_acc} = {m_acc, 1'b0};
			CLS_LSR: {m_acc, m_st[FLAG_C]} = {1'b0, m_acc};
			CLS_ROL: {m_st[FLAG_C], m_acc} = {m_acc, c};
			CLS_ROR: {m_acc, m_st[FLAG_C]} = {c, m_acc};
			CLS_SEC: m_st[FLAG_C] = 1'b1;
			CLS_CLC: m_st[FLAG_C] = 1'b0;
			CLS_SED: m_st[FLAG_D] = 1'b1;
			CLS_CLD: m_st[FLAG_D] = 1'b0;
			default: ;
		endcase
		if (!(cls inside {CLS_CMP, CLS_SEC, CLS_CLC, CLS_SED, CLS_CLD}))
			set_nz(m_acc);
	endtask

	// One command, optional stall window and a second strobe while busy
	task automatic exec_cmd(input insn_class_t cls, input byte_t opnd,
			input int stall_at, input int stall_len, input bit poke);
		int      lat;
		int      exp_lat;
		bit      stalled;
		bit      decimal;
		byte_t   acc_hold;
		status_t st_hold;
		decimal = m_st[FLAG_D] && (cls inside {CLS_ADC, CLS_SBC});
		exp_lat = (decimal ? 3 : 2) + ((stall_at >= 0) ? stall_len : 0);
		lat = 0;
		acc_hold = acc;
		st_hold = status;
		cmd_class = cls;
		cmd_operand = opnd;
		cmd_valid = 1'b1;
		@(posedge clk);
		#2;
		assert (busy === 1'b1) else note_error("command was not accepted");
		cmd_valid = poke;
		cmd_class = CLS_LDA;    // Would overwrite A if taken
		cmd_operand = ~opnd;
		while (done !== 1'b1) begin
			if (lat == 1)
				cmd_valid = 1'b0;
			if (lat == stall_at)
				rdy = 1'b0;
			if (lat == stall_at + stall_len)
				rdy = 1'b1;
			stalled = !rdy;
			@(posedge clk);
			#2;
			lat++;
			if (stalled)
				assert (acc === acc_hold && status === st_hold && done === 1'b0)
					else note_error("A, flags or done moved while rdy was low");
		end
		assert (lat == exp_lat) else report_mismatch("done latency", exp_lat, lat);
		model_step(cls, opnd);
		if (decimal)
			m_st[FLAG_V] = status[FLAG_V];  // V undefined in decimal mode
		assert (acc === m_acc) else report_mismatch("acc", m_acc, acc);
		assert (status === m_st) else report_mismatch("status", m_st, status);
	endtask

	task automatic issue(input insn_class_t cls, input byte_t opnd);
		exec_cmd(cls, opnd, -1, 0, 1'b0);
	endtask

	task automatic close_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%-14s ok", name);
		end else begin
			tests_bad++;
			$display("%-14s %0d errors", name, errors - err_before);
		end
	endtask

	task automatic test_reset_flags();
		assert (acc === 8'h00) else report_mismatch("acc", 0, acc);
		assert (status === '0) else report_mismatch("status", 0, status);
		assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
		assert (done === 1'b0) else report_mismatch("done", 0, done);
		issue(CLS_LDA, 8'h80);  // N set so side effects show
		issue(CLS_SEC, 8'h00);
		issue(CLS_SED, 8'h00);
		issue(CLS_CLC, 8'h00);
		issue(CLS_CLD, 8'h00);
	endtask

	task automatic test_binary_arith();
		int sel;
		for (int i = 0; i < 64; i++) begin
			if (i % 8 == 0)
				issue(CLS_LDA, rand_byte());
			sel = $unsigned($random(seed)) % 3;
			issue(sel == 0 ? CLS_ADC : (sel == 1 ? CLS_SBC : CLS_CMP), rand_byte());
		end
	endtask

	task automatic test_logic_lda();
		insn_class_t ops [4] = '{CLS_AND, CLS_ORA, CLS_EOR, CLS_LDA};
		issue(CLS_LDA, 8'h7f);
		issue(CLS_ADC, 8'h01);  // Leaves V set for the logic ops to keep
		for (int i = 0; i < 16; i++)
			issue(ops[$unsigned($random(seed)) % 4], rand_byte());
	endtask

	task automatic test_shifts();
		insn_class_t ops [4] = '{CLS_ASL, CLS_LSR, CLS_ROL, CLS_ROR};
		for (int c = 0; c < 2; c++) begin
			for (int k = 0; k < 4; k++) begin
				for (int i = 0; i < 3; i++) begin
					issue(c ? CLS_SEC : CLS_CLC, 8'h00);
					issue(CLS_LDA, rand_byte());
					issue(ops[k], 8'h00);
				end
			end
		end
	endtask

	task automatic test_decimal();
		issue(CLS_SED, 8'h00);
		for (int i = 0; i < 32; i++) begin
			issue(CLS_LDA, to_bcd($unsigned($random(seed)) % 100));
			issue(($random(seed) & 1) ? CLS_SEC : CLS_CLC, 8'h00);
			issue((i % 2) ? CLS_SBC : CLS_ADC, to_bcd($unsigned($random(seed)) % 100));
		end
		issue(CLS_CLD, 8'h00);
		issue(CLS_LDA, 8'h19);
		issue(CLS_CLC, 8'h00);
		issue(CLS_ADC, 8'h28);  // Binary 0x41, not 0x47
	endtask

	task automatic test_stall();
		issue(CLS_LDA, rand_byte());
		issue(CLS_CLC, 8'h00);
		exec_cmd(CLS_ADC, rand_byte(), 1, 3, 1'b1);  // Stalled in WRITE, LDA strobe dropped
		rdy = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#2;
			assert (done === 1'b1) else note_error("done fell while rdy was low");
		end
		rdy = 1'b1;
		@(posedge clk);
		#2;
		assert (done === 1'b0) else note_error("done stayed high after rdy returned");
		assert (busy === 1'b0) else note_error("strobe raised while busy started a command");
		exec_cmd(CLS_SBC, rand_byte(), 0, 2, 1'b0);  // Stalled before the ALU edge
	endtask

	initial begin
		rst = 1'b1;
		rdy = 1'b1;
		cmd_valid = 1'b0;
		cmd_class = CLS_ADC;
		cmd_operand = 8'h00;
		m_acc = 8'h00;
		m_st = '0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		err_mark = errors;
		test_reset_flags();
		close_test("reset_flags", err_mark);
		err_mark = errors;
		test_binary_arith();
		close_test("binary_arith", err_mark);
		err_mark = errors;
		test_logic_lda();
		close_test("logic_lda", err_mark);
		err_mark = errors;
		test_shifts();
		close_test("shifts", err_mark);
		err_mark = errors;
		test_decimal();
		close_test("decimal", err_mark);
		err_mark = errors;
		test_stall();
		close_test("stall", err_mark);
		prop_fails = DUT.u_props.fail_count;
		$display("Summary: %0d tests, %0d with errors, %0d check errors, %0d assertion failures",
			tests_run, tests_bad, errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/alu_datapath_props.sv
`timescale 1ns/1ps
`default_nettype none

module alu_datapath_props
	import alu_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       rdy,
	input logic       cmd_valid,
	input logic       busy,
	input logic       done,
	input logic       commit,
	input seq_state_t state
);

	int fail_count = 0;  // Read by the testbench summary

	// Single done pulse unless stalled
	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done && rdy |=> !done)
		else begin fail_count++; $error("done stayed high for more than one cycle"); end

	// Two unstalled edges binary, three through the adjuster
	a_latency: assert property (@(posedge clk) disable iff (rst)
		cmd_valid && !busy && rdy |=> (rdy[->2] ##1 done) or (rdy[->3] ##1 done))
		else begin fail_count++; $error("done did not follow acceptance in time"); end

	a_reset_idle: assert property (@(posedge clk) rst |=> !busy && !done)
		else begin fail_count++; $error("busy or done high after reset"); end

	// Unstalled commit raises done and frees the sequencer
	a_commit_state: assert property (@(posedge clk) disable iff (rst)
		commit && rdy |=> done && state == IDLE)
		else begin fail_count++; $error("done or IDLE did not follow a commit"); end

endmodule

bind alu_datapath alu_datapath_props u_props (.clk(clk), .rst(rst), .rdy(rdy),
	.cmd_valid(cmd_valid), .busy(busy), .done(done), .commit(commit), .state(u_seq.state));

`default_nettype wire

//--- hw/alu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module alu_datapath
	import cpu_pkg::*, alu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        rdy,          // Global stall, low freezes everything
	input  logic        cmd_valid,
	input  insn_class_t cmd_class,
	input  byte_t       cmd_operand,
	output byte_t       acc,
	output status_t     status,
	output logic        busy,
	output logic        done
);

	// Sequencer to ALU
	logic    alu_ce, alu_right, alu_ci, alu_bcd;
	alu_op_t alu_op;
	byte_t   alu_ai, alu_bi;
	// ALU results
	byte_t   alu_out;
	logic    alu_co, alu_hc, alu_n, alu_z, alu_v;
	// Adjuster control and corrected result
	logic    adj_en, adj_sub;
	byte_t   res;
	logic    res_n, res_z;
	// Commit controls
	logic    commit, wr_acc, upd_nz, upd_c, upd_v;
	logic    flag_wr, flag_sel, flag_val;

	alu_sequencer u_seq (.clk(clk), .rst(rst), .rdy(rdy), .cmd_valid(cmd_valid),
		.cmd_class(cmd_class), .cmd_operand(cmd_operand), .acc(acc), .status(status),
		.busy(busy), .done(done), .alu_ce(alu_ce), .alu_op(alu_op), .alu_right(alu_right),
		.alu_ai(alu_ai), .alu_bi(alu_bi), .alu_ci(alu_ci), .alu_bcd(alu_bcd),
		.adj_en(adj_en), .adj_sub(adj_sub), .commit(commit), .wr_acc(wr_acc),
		.upd_nz(upd_nz), .upd_c(upd_c), .upd_v(upd_v), .flag_wr(flag_wr),
		.flag_sel(flag_sel), .flag_val(flag_val));

	alu u_alu (.clk(clk), .ce(alu_ce), .rdy(rdy), .op(alu_op), .right(alu_right),
		.ai(alu_ai), .bi(alu_bi), .ci(alu_ci), .bcd(alu_bcd), .out_byte(alu_out),
		.co(alu_co), .v(alu_v), .z(alu_z), .n(alu_n), .hc(alu_hc));

	decimal_adjust u_adj (.clk(clk), .rst(rst), .rdy(rdy), .alu_ce(alu_ce),
		.adj_en(adj_en), .adj_sub(adj_sub), .alu_out(alu_out), .alu_co(alu_co),
		.alu_hc(alu_hc), .alu_n(alu_n), .alu_z(alu_z), .res(res), .res_n(res_n),
		.res_z(res_z));

	arch_regs u_regs (.clk(clk), .rst(rst), .rdy(rdy), .commit(commit), .wr_acc(wr_acc),
		.upd_nz(upd_nz), .upd_c(upd_c), .upd_v(upd_v), .res(res), .res_n(res_n),
		.res_z(res_z), .alu_co(alu_co), .alu_v(alu_v), .flag_wr(flag_wr),
		.flag_sel(flag_sel), .flag_val(flag_val), .acc(acc), .status(status));

endmodule

`default_nettype wire

//--- hw/alu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer
	import cpu_pkg::*, alu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        rdy,
	input  logic        cmd_valid,
	input  insn_class_t cmd_class,
	input  byte_t       cmd_operand,
	input  byte_t       acc,
	input  status_t     status,
	output logic        busy,
	output logic        done,
	output logic        alu_ce,
	output alu_op_t     alu_op,
	output logic        alu_right,
	output byte_t       alu_ai,
	output byte_t       alu_bi,
	output logic        alu_ci,
	output logic        alu_bcd,
	output logic        adj_en,
	output logic        adj_sub,
	output logic        commit,
	output logic        wr_acc,
	output logic        upd_nz,
	output logic        upd_c,
	output logic        upd_v,
	output logic        flag_wr,
	output logic        flag_sel,
	output logic        flag_val
);

	seq_state_t state;
	logic       accept;
	alu_op_t    d_op;
	logic [3:0] d_we;        // wr_acc, upd_nz, upd_c, upd_v
	logic       d_ci;
	logic       d_adc;
	logic       d_sbc;
	logic [3:0] we_q;
	logic [2:0] flag_q;      // flag_wr, flag_sel, flag_val
	logic       dec_q;       // Route through ADJUST

	assign accept = (state == IDLE) && cmd_valid && rdy;
	assign d_adc  = (cmd_class == CLS_ADC);
	assign d_sbc  = (cmd_class == CLS_SBC);

	always_comb begin
		case (cmd_class)
			CLS_ADC:                   d_op = ALU_ADD;
			CLS_SBC, CLS_CMP:          d_op = ALU_SUB;
			CLS_AND:                   d_op = ALU_AND;
			CLS_ORA:                   d_op = ALU_OR;
			CLS_EOR:                   d_op = ALU_XOR;
			CLS_ASL, CLS_ROL:          d_op = ALU_DBL;
			default:                   d_op = ALU_PASS;  // LDA, right shifts, flag ops
		endcase
		case (cmd_class)
			CLS_ADC, CLS_SBC:          d_we = 4'b1111;
			CLS_CMP:                   d_we = 4'b0110;   // Flags only
			CLS_AND, CLS_ORA, CLS_EOR: d_we = 4'b1100;
			CLS_LDA:                   d_we = 4'b1100;
			CLS_ASL, CLS_LSR:          d_we = 4'b1110;
			CLS_ROL, CLS_ROR:          d_we = 4'b1110;
			default:                   d_we = 4'b0000;
		endcase
	end

	// Carry enters through C for arithmetic and rotates
	assign d_ci = (cmd_class == CLS_CMP) ||
		(status[FLAG_C] && (cmd_class inside {CLS_ADC, CLS_SBC, CLS_ROL, CLS_ROR}));

	// Operand payload, latched once per command
	always_ff @(posedge clk) begin
		if (accept) begin
			alu_op    <= d_op;
			alu_right <= cmd_class inside {CLS_LSR, CLS_ROR};
			alu_ai    <= (cmd_class == CLS_LDA) ? cmd_operand : acc;
			alu_bi    <= cmd_operand;
			alu_ci    <= d_ci;
			alu_bcd   <= d_adc && status[FLAG_D];
			adj_sub   <= d_sbc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= IDLE;
			done   <= 1'b0;
			we_q   <= '0;
			flag_q <= '0;
			dec_q  <= 1'b0;
		end else if (rdy) begin
			done <= (state == WRITE);  // Held through a stall
			case (state)
				IDLE: begin
					if (accept) begin
						state  <= EXEC;
						we_q   <= d_we;
						flag_q <= {cmd_class inside {CLS_SEC, CLS_CLC, CLS_SED, CLS_CLD},
							cmd_class inside {CLS_SED, CLS_CLD},
							cmd_class inside {CLS_SEC, CLS_SED}};
						dec_q  <= (d_adc || d_sbc) && status[FLAG_D];
					end
				end
				EXEC:    state <= dec_q ? ADJUST : WRITE;
				ADJUST:  state <= WRITE;
				default: state <= IDLE;  // WRITE
			endcase
		end
	end

	assign busy   = (state != IDLE);
	assign alu_ce = (state == EXEC);
	assign adj_en = (state == ADJUST);
	assign commit = (state == WRITE);
	assign {wr_acc, upd_nz, upd_c, upd_v} = we_q;
	assign {flag_wr, flag_sel, flag_val} = flag_q;

endmodule

`default_nettype wire

//--- hw/arch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module arch_regs
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    rdy,
	input  logic    commit,    // Apply the enables below this cycle
	input  logic    wr_acc,
	input  logic    upd_nz,
	input  logic    upd_c,
	input  logic    upd_v,
	input  byte_t   res,
	input  logic    res_n,
	input  logic    res_z,
	input  logic    alu_co,
	input  logic    alu_v,
	input  logic    flag_wr,   // Direct flag set or clear
	input  logic    flag_sel,  // 0 picks C, 1 picks D
	input  logic    flag_val,
	output byte_t   acc,
	output status_t status
);

	always_ff @(posedge clk) begin
		if (rst) begin
			acc    <= '0;
			status <= '0;
		end else if (rdy && commit) begin
			if (wr_acc) begin
				acc <= res;
			end
			if (upd_nz) begin
				status[FLAG_N] <= res_n;
				status[FLAG_Z] <= res_z;
			end
			if (upd_c) begin
				status[FLAG_C] <= alu_co;  // Also the shifted-out bit
			end
			if (upd_v) begin
				status[FLAG_V] <= alu_v;
			end
			if (flag_wr) begin
				if (flag_sel) begin
					status[FLAG_D] <= flag_val;
				end else begin
					status[FLAG_C] <= flag_val;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/decimal_adjust.sv
`timescale 1ns/1ps
`default_nettype none

module decimal_adjust
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  rdy,
	input  logic  alu_ce,
	input  logic  adj_en,
	input  logic  adj_sub,   // Correct a subtract instead of an add
	input  byte_t alu_out,
	input  logic  alu_co,
	input  logic  alu_hc,
	input  logic  alu_n,
	input  logic  alu_z,
	output byte_t res,
	output logic  res_n,
	output logic  res_z
);

	nibble_t lo_adj;
	nibble_t hi_adj;
	byte_t   res_q;
	logic    valid;          // Corrected byte belongs to the current op

	// Add 6 on digit carry, remove 6 on digit borrow
	always_comb begin
		if (adj_sub) begin
			lo_adj = alu_hc ? alu_out[3:0] : alu_out[3:0] - 4'd6;
			hi_adj = alu_co ? alu_out[7:4] : alu_out[7:4] - 4'd6;
		end else begin
			lo_adj = alu_hc ? alu_out[3:0] + 4'd6 : alu_out[3:0];
			hi_adj = alu_co ? alu_out[7:4] + 4'd6 : alu_out[7:4];
		end
	end

	always_ff @(posedge clk) begin
		if (rdy && adj_en) begin
			res_q <= {hi_adj, lo_adj};
		end
	end

	// Next ALU op invalidates the corrected byte
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else if (rdy) begin
			if (adj_en) begin
				valid <= 1'b1;
			end else if (alu_ce) begin
				valid <= 1'b0;
			end
		end
	end

	assign res   = valid ? res_q : alu_out;
	assign res_n = valid ? res_q[7] : alu_n;
	assign res_z = valid ? ~|res_q : alu_z;  // Z from the corrected digits

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*, alu_pkg::*;
(
	input  logic    clk,
	input  logic    ce,        // Register enable, one cycle per op
	input  logic    rdy,       // Global stall when low
	input  alu_op_t op,
	input  logic    right,     // Right shift through the logic stage
	input  byte_t   ai,
	input  byte_t   bi,
	input  logic    ci,
	input  logic    bcd,       // Decimal style carries on add
	output byte_t   out_byte,
	output logic    co,
	output logic    v,
	output logic    z,
	output logic    n,
	output logic    hc         // Half carry out of the low digit
);

	logic [8:0] logic_res;     // Bit 8 only used by right shifts
	byte_t      bi_sel;
	logic [4:0] sum_lo;
	logic [4:0] sum_hi;
	logic [8:0] sum;
	logic       adder_ci;
	logic       hc9;
	logic       co9;
	logic       hc_int;
	logic       ai7_q;         // Operand signs kept for overflow
	logic       bi7_q;

	// Carry in only reaches the adder for add, sub and double
	assign adder_ci = (right || (op[3:2] == 2'b11)) ? 1'b0 : ci;

	// Logic stage
	always_comb begin
		case (op[1:0])
			2'b00:   logic_res = {1'b0, ai | bi};
			2'b01:   logic_res = {1'b0, ai & bi};
			2'b10:   logic_res = {1'b0, ai ^ bi};
			default: logic_res = {1'b0, ai};
		endcase
		if (right) begin
			logic_res = {ai[0], ci, ai[7:1]};  // Shifted-out bit lands in carry
		end
	end

	// Second adder input
	always_comb begin
		case (op[3:2])
			2'b00:   bi_sel = bi;              // A + B
			2'b01:   bi_sel = ~bi;             // A - B
			2'b10:   bi_sel = logic_res[7:0];  // A + A
			default: bi_sel = '0;              // Logic result alone
		endcase
	end

	// Adder split into digits to expose the half carry
	assign sum_lo = {1'b0, logic_res[3:0]} + {1'b0, bi_sel[3:0]} + {4'b0, adder_ci};

	// Digit above 9 counts as a carry in decimal add
	assign hc9    = bcd & (sum_lo[3:1] >= 3'd5);
	assign hc_int = sum_lo[4] | hc9;

	assign sum_hi = logic_res[8:4] + {1'b0, bi_sel[7:4]} + {4'b0, hc_int};
	assign co9    = bcd & (sum_hi[3:1] >= 3'd5);
	assign sum    = {sum_hi, sum_lo[3:0]};

	// Result register, held through stalls and later pipeline steps
	always_ff @(posedge clk) begin
		if (ce && rdy) begin
			ai7_q    <= ai[7];
			bi7_q    <= bi_sel[7];
			out_byte <= sum[7:0];
			co       <= sum[8] | co9;
			n        <= sum[7];
			hc       <= hc_int;
		end
	end

	// Carry into bit 7 differs from carry out on signed overflow
	assign v = ai7_q ^ bi7_q ^ co ^ n;
	assign z = ~|out_byte;

endmodule

`default_nettype wire

//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// ALU operation, upper two bits pick the adder B source,
	// lower two bits pick the logic function
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD  = 4'b0011;  // AI + BI
	localparam alu_op_t ALU_SUB  = 4'b0111;  // AI + ~BI
	localparam alu_op_t ALU_DBL  = 4'b1011;  // AI + AI, left shifts
	localparam alu_op_t ALU_OR   = 4'b1100;  // AI | BI
	localparam alu_op_t ALU_AND  = 4'b1101;  // AI & BI
	localparam alu_op_t ALU_XOR  = 4'b1110;  // AI ^ BI
	localparam alu_op_t ALU_PASS = 4'b1111;  // AI, also right shifts

	// Instruction class carried by a command
	typedef logic [3:0] insn_class_t;

	localparam insn_class_t CLS_ADC = 4'd0;
	localparam insn_class_t CLS_SBC = 4'd1;
	localparam insn_class_t CLS_CMP = 4'd2;
	localparam insn_class_t CLS_AND = 4'd3;
	localparam insn_class_t CLS_ORA = 4'd4;
	localparam insn_class_t CLS_EOR = 4'd5;
	localparam insn_class_t CLS_ASL = 4'd6;
	localparam insn_class_t CLS_LSR = 4'd7;
	localparam insn_class_t CLS_ROL = 4'd8;
	localparam insn_class_t CLS_ROR = 4'd9;
	localparam insn_class_t CLS_LDA = 4'd10;
	localparam insn_class_t CLS_SEC = 4'd11;
	localparam insn_class_t CLS_CLC = 4'd12;
	localparam insn_class_t CLS_SED = 4'd13;
	localparam insn_class_t CLS_CLD = 4'd14;  // 15 unused, decodes as no-op

	// Sequencer states
	typedef enum logic [1:0] {IDLE, EXEC, ADJUST, WRITE} seq_state_t;

endpackage

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Architectural data widths
	typedef logic [7:0] byte_t;    // One data word
	typedef logic [3:0] nibble_t;  // Single BCD digit

	// Status register, only the flags this core implements
	typedef logic [4:0] status_t;

	// Bit positions inside status_t
	localparam int FLAG_C = 0;  // Carry, inverted borrow on subtract
	localparam int FLAG_Z = 1;  // Zero result
	localparam int FLAG_D = 2;  // Decimal mode
	localparam int FLAG_V = 3;  // Signed overflow
	localparam int FLAG_N = 4;  // Bit 7 of result

	// Packed in this order so the vector stays dense
	// while keeping the 6502 relative ordering of C, Z, D, V, N

endpackage

`default_nettype wire
